//--- bench/neoC1Tb.sv
`timescale 1ns/10ps

module neoC1Tb;
	import c1Pkg::*;

	localparam int NUM_RANDOM = 250;
	localparam int MAX_CYCLES = 400 * 5;	// 400 bus cycles of at most five clocks

	logic CLK_68KCLK = 1'b0;
	logic rstN;
	logic [21:17] m68kAddr;
	logic a22z, a23z, nLds, nUds, rw, nAs;
	byteT m68kDataIn, m68kData, sdd, soundCmd;
	logic nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs;
	logic nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU;
	logic nSramOeL, nSramOeU, nSramWeL, nSramWeU, nLspOe, nLspWe;
	logic nCrdO, nCrdW, nCrdC, nBitW0, nBitW1, nDipRd0, nDipRd1, nPal;
	padT p1In, p2In;
	logic nCd1, nCd2, nWp, nRomWait, nPWait0, nPWait1, pDtack, systemMode;
	logic nDtack, nSdw;

	logic [15:0] lfsr = 16'd54542;
	byteT expCmd;
	int cycleCnt = 0;
	int strobeErrs = 0;
	int dataErrs = 0;
	int ackErrs = 0;
	string strobeNames[27] = '{"nRomOeL", "nRomOeU", "nPortOeL", "nPortOeU", "nPortWeL",
		"nPortWeU", "nPortAdrs", "nWrL", "nWrU", "nWwL", "nWwU", "nSromOeL", "nSromOeU",
		"nSramOeL", "nSramOeU", "nSramWeL", "nSramWeU", "nLspOe", "nLspWe", "nCrdO",
		"nCrdW", "nCrdC", "nBitW0", "nBitW1", "nDipRd0", "nDipRd1", "nPal"};

	neoC1 dut (.*);

	always #4 CLK_68KCLK = ~CLK_68KCLK;

	always @(posedge CLK_68KCLK) begin
		cycleCnt++;
		if (cycleCnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, run did not finish", cycleCnt);
			$display("Test failed");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic getBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic zoneE refZone(input addrHiT a);
		case (a[6:3])
			4'b0000: return rom;
			4'b0001: return wram;
			4'b0010: return port;
			4'b0011: return io;
			4'b0100, 4'b0101, 4'b0110, 4'b0111: return pal;
			4'b1000, 4'b1001, 4'b1010, 4'b1011: return card;
			4'b1100: return srom;
			4'b1101: return sram;
			default: return none;
		endcase
	endfunction

	// Built as active-high enables and inverted at the end
	function automatic logic [26:0] refStrobes(input addrHiT a, input logic r, ul, uu, as);
		logic [26:0] act;
		zoneE z;
		logic rd, wr, word, isIo;
		z = refZone(a);
		rd = !as && r;
		wr = !as && !r;
		word = !ul && !uu;
		isIo = (z == io);
		act[0] = rd && !ul && z == rom;
		act[1] = rd && !uu && z == rom;
		act[2] = rd && !ul && z == port;
		act[3] = rd && !uu && z == port;
		act[4] = wr && !ul && z == port;
		act[5] = wr && !uu && z == port;
		act[6] = !as && z == port;
		act[7] = rd && !ul && z == wram;
		act[8] = rd && !uu && z == wram;
		act[9] = wr && !ul && z == wram;
		act[10] = wr && !uu && z == wram;
		act[11] = rd && !ul && z == srom;
		act[12] = rd && !uu && z == srom;
		act[13] = rd && !ul && z == sram;
		act[14] = rd && !uu && z == sram;
		act[15] = wr && !ul && z == sram;
		act[16] = wr && !uu && z == sram;
		act[17] = rd && word && isIo && a[2:0] == 3'b110;	// Video controller
		act[18] = wr && word && isIo && a[2:0] == 3'b110;
		act[19] = rd && word && z == card;
		act[20] = wr && word && z == card;
		act[21] = act[19] || act[20];
		act[22] = wr && !ul && isIo && a[2:0] == 3'b100;
		act[23] = wr && !ul && isIo && a[2:0] == 3'b101;
		act[24] = rd && !ul && isIo && a[2:0] == 3'b000;
		act[25] = rd && !ul && isIo && a[2:0] == 3'b001;
		act[26] = !as && z == pal;
		return ~act;
	endfunction

	function automatic byteT refRead(input addrHiT a, input logic r, uu, as);
		if (as || uu || refZone(a) != io)
			return 8'hFF;
		if (a[2:0] == 3'b001)
			return sdd;
		if (!r)
			return 8'hFF;
		case (a[2:0])
			3'b000: return p1In[7:0];
			3'b010, 3'b011: return p2In[7:0];
			3'b100: return {systemMode, nWp, nCd2, nCd1, p2In[9:8], p1In[9:8]};
			default: return 8'hFF;
		endcase
	endfunction

	function automatic waitCntT refWait(input addrHiT a);
		case (refZone(a))
			rom: return {1'b0, !nRomWait};
			port: return {!nPWait1, !nPWait0};
			card: return CARD_WAIT_DEF;
			default: return 2'd0;
		endcase
	endfunction

	task automatic compareBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
			strobeErrs++;
		end
	endtask

	task automatic compareByte(input string name, input byteT got, input byteT exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			dataErrs++;
		end
	endtask

	task automatic compareZone(input zoneE got, input zoneE exp);
		if (got !== exp) begin
			$display("Error at %0t: zone got %s expected %s", $time, got.name(), exp.name());
			strobeErrs++;
		end
	endtask

	task automatic compareLatency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t: %s latency got %0d expected %0d", $time, name, got, exp);
			ackErrs++;
		end
	endtask

	task automatic compareStrobes(input logic [26:0] exp);
		logic [26:0] got;
		got = {nPal, nDipRd1, nDipRd0, nBitW1, nBitW0, nCrdC, nCrdW, nCrdO, nLspWe, nLspOe,
			nSramWeU, nSramWeL, nSramOeU, nSramOeL, nSromOeU, nSromOeL, nWwU, nWwL, nWrU, nWrL,
			nPortAdrs, nPortWeU, nPortWeL, nPortOeU, nPortOeL, nRomOeU, nRomOeL};
		for (int i = 0; i < 27; i++)
			compareBit(strobeNames[i], got[i], exp[i]);
	endtask

	// One complete bus cycle where hold keeps pDtack high for three edges
	task automatic runCycle(input addrHiT a, input logic r, ul, uu, input byteT din,
		input logic hold);
		int edges;
		int expLat;
		logic cmdWr;
		@(negedge CLK_68KCLK);
		{a23z, a22z, m68kAddr} = a;
		rw = r;
		nLds = ul;
		nUds = uu;
		m68kDataIn = din;
		pDtack = hold;
		nAs = 1'b0;
		#1;
		compareStrobes(refStrobes(a, r, ul, uu, 1'b0));
		compareZone(dut.zone, refZone(a));
		if (r)
			compareByte("m68kData", m68kData, refRead(a, r, uu, 1'b0));
		cmdWr = refZone(a) == io && a[2:0] == 3'b001 && !r && !uu;
		expLat = hold ? 4 : int'(refWait(a)) + 1;
		edges = 0;
		while (1) begin
			@(negedge CLK_68KCLK);
			edges++;
			compareBit("nSdw", nSdw, !(cmdWr && edges == 1));
			if (!nDtack)
				break;
			if (hold && edges == 3)
				pDtack = 1'b0;	// Cartridge releases
			if (edges > 8) begin
				$display("Error at %0t: nDtack never fell", $time);
				ackErrs++;
				break;
			end
		end
		compareLatency("nDtack", edges, expLat);
		if (cmdWr)
			expCmd = din;
		compareByte("soundCmd", soundCmd, expCmd);
		nAs = 1'b1;
		pDtack = 1'b0;
		#1;
		compareStrobes(refStrobes(a, r, ul, uu, 1'b1));
		compareByte("m68kData", m68kData, 8'hFF);
		@(negedge CLK_68KCLK);
		compareBit("nDtack", nDtack, 1'b1);
		compareBit("nSdw", nSdw, 1'b1);
	endtask

	task automatic randomCycle();
		logic [15:0] v;
		addrHiT a;
		logic r, ul, uu;
		byteT din;
		getBits(7, v);
		a = v[6:0];
		getBits(1, v);
		if (v[0])
			a[6:3] = 4'b0011;	// Bias toward the register zone
		getBits(3, v);
		{r, ul, uu} = v[2:0];
		getBits(8, v);
		din = v[7:0];
		getBits(10, v);
		p1In = v[9:0];
		getBits(10, v);
		p2In = v[9:0];
		getBits(8, v);
		sdd = v[7:0];
		getBits(7, v);
		{nCd1, nCd2, nWp, systemMode, nRomWait, nPWait0, nPWait1} = v[6:0];
		runCycle(a, r, ul, uu, din, 1'b0);
	endtask

	initial begin
		rstN = 1'b0;
		m68kAddr = '0;
		{a22z, a23z} = 2'b00;
		{nLds, nUds, rw, nAs} = 4'b1111;
		m68kDataIn = '0;
		p1In = '0;
		p2In = '0;
		{nCd1, nCd2, nWp, systemMode} = 4'b1110;
		{nRomWait, nPWait0, nPWait1, pDtack} = 4'b1110;
		sdd = 8'h5A;
		expCmd = '0;
		repeat (8) @(negedge CLK_68KCLK);
		rstN = 1'b1;
		#1;
		compareBit("nDtack", nDtack, 1'b1);
		compareBit("nSdw", nSdw, 1'b1);
		compareByte("soundCmd", soundCmd, 8'h00);

		// Register reads and the command register
		p1In = 10'h2A5;
		p2In = 10'h13C;
		runCycle(7'b0011000, 1'b1, 1'b1, 1'b0, 8'h00, 1'b0);
		runCycle(7'b0011010, 1'b1, 1'b1, 1'b0, 8'h00, 1'b0);
		runCycle(7'b0011100, 1'b1, 1'b1, 1'b0, 8'h00, 1'b0);
		runCycle(7'b0011001, 1'b0, 1'b1, 1'b0, 8'hC3, 1'b0);
		runCycle(7'b0011001, 1'b1, 1'b1, 1'b0, 8'h77, 1'b0);
		runCycle(7'b0011001, 1'b0, 1'b0, 1'b0, 8'h3C, 1'b0);

		// Wait states
		nRomWait = 1'b0;
		runCycle(7'b0000011, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0);
		nRomWait = 1'b1;
		runCycle(7'b0000011, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0);
		{nPWait1, nPWait0} = 2'b00;
		runCycle(7'b0010000, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0);
		runCycle(7'b1000101, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
		{nPWait1, nPWait0} = 2'b11;
		runCycle(7'b0010110, 1'b1, 1'b0, 1'b0, 8'h00, 1'b1);
		runCycle(7'b0010001, 1'b0, 1'b0, 1'b1, 8'h00, 1'b1);

		for (int i = 0; i < NUM_RANDOM; i++)
			randomCycle();

		$display("Errors: strobe %0d, data %0d, acknowledge %0d", strobeErrs, dataErrs, ackErrs);
		if (strobeErrs + dataErrs + ackErrs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- design/c1BusIf.sv
`timescale 1ns/10ps

interface c1BusIf ();
	import c1Pkg::*;

	addrHiT addrHi;	// A23..A17
	logic rw;	// High for read
	logic nAs;	// Address strobe
	logic nLds;	// Lower byte, odd addresses
	logic nUds;	// Upper byte, even addresses

	// Full view for the address decoder
	modport decode (
		input addrHi,
		input rw,
		input nAs,
		input nLds,
		input nUds
	);

	// Wait generator only follows the address strobe
	modport waiter (
		input nAs
	);

	// Command register
	modport regs (
		input rw,
		input nUds
	);

endinterface

//--- design/c1Comm.sv
`timescale 1ns/10ps

module c1Comm (
	input logic CLK_68KCLK,
	input logic rstN,
	c1BusIf.regs bus,
	input logic nIcomZone,
	input c1Pkg::byteT m68kDataIn,
	output c1Pkg::byteT soundCmd,
	output logic nSdw
);

	logic cmdWr;	// Write on the upper lane to the command register
	logic wrSeen;	// Current access already latched

	assign cmdWr = ~nIcomZone & ~bus.rw & ~bus.nUds;

	always_ff @(posedge CLK_68KCLK or negedge rstN) begin
		if (!rstN) begin
			soundCmd <= '0;
			nSdw <= 1'b1;
			wrSeen <= 1'b0;
		end else begin
			nSdw <= 1'b1;
			if (cmdWr && !wrSeen) begin
				soundCmd <= m68kDataIn;
				nSdw <= 1'b0;	// Tells the sound CPU a command is waiting
			end
			// Zone drops with nAs, which rearms the latch
			wrSeen <= cmdWr;
		end
	end

	// One strobe per access even for long wait cycles
	assert property (@(posedge CLK_68KCLK) disable iff (!rstN)
		!nSdw |=> nSdw)
		else $error("c1Comm: nSdw low for two cycles");

endmodule

//--- design/c1Decode.sv
`timescale 1ns/10ps

module c1Decode (
	c1BusIf.decode bus,
	output logic nRomOeL, nRomOeU,
	output logic nPortOeL, nPortOeU,
	output logic nPortWeL, nPortWeU,
	output logic nPortAdrs,
	output logic nWrL, nWrU,
	output logic nWwL, nWwU,
	output logic nSromOeL, nSromOeU,
	output logic nSramOeL, nSramOeU,
	output logic nSramWeL, nSramWeU,
	output logic nLspOe, nLspWe,
	output logic nCrdO, nCrdW, nCrdC,
	output logic nBitW0, nBitW1,
	output logic nDipRd0, nDipRd1,
	output logic nPal,
	output logic nRomZone,
	output logic nPortZone,
	output logic nCardZone,
	output logic nCtrl1Zone,
	output logic nCtrl2Zone,
	output logic nStatusbZone,
	output logic nIcomZone,
	output c1Pkg::zoneE zone
);
	import c1Pkg::*;

	logic a19, a18, a17;
	logic nWramZone, nIoZone, nPalZone, nSromZone, nSramZone;
	logic nC1RegsZone;	// Even bytes of the I/O zone
	logic nLspcZone;
	logic nWordAccess;
	logic nRd, nWr;	// Qualified read and write cycles

	assign a19 = bus.addrHi[2];
	assign a18 = bus.addrHi[1];
	assign a17 = bus.addrHi[0];

	// Top level split on A23..A20
	always_comb begin
		casez (bus.addrHi[6:3])
			4'b0000: zone = rom;
			4'b0001: zone = wram;
			4'b0010: zone = port;
			4'b0011: zone = io;
			4'b01??: zone = pal;
			4'b10??: zone = card;
			4'b1100: zone = srom;
			4'b1101: zone = sram;
			default: zone = none;
		endcase
	end

	assign nRomZone = (zone != rom);
	assign nWramZone = (zone != wram);
	assign nPortZone = (zone != port);
	assign nIoZone = (zone != io);
	assign nPalZone = (zone != pal);
	assign nCardZone = (zone != card);
	assign nSromZone = (zone != srom);
	assign nSramZone = (zone != sram);

	assign nRd = ~bus.rw | bus.nAs;
	assign nWr = bus.rw | bus.nAs;
	assign nWordAccess = bus.nLds | bus.nUds;

	// Register space in 128k steps on A19..A17
	assign nC1RegsZone = bus.nUds | nIoZone | bus.nAs;
	assign nCtrl1Zone = nC1RegsZone | ~bus.rw | a19 | a18 | a17;	// 30xxxx-31xxxx
	assign nIcomZone = nC1RegsZone | a19 | a18 | ~a17;	// 32xxxx-33xxxx both ways
	assign nCtrl2Zone = nC1RegsZone | ~bus.rw | a19 | ~a18;	// 34xxxx-37xxxx
	assign nStatusbZone = nC1RegsZone | ~bus.rw | ~a19 | a18 | a17;	// 38xxxx-39xxxx
	assign nLspcZone = nIoZone | ~a19 | ~a18 | a17;	// 3Cxxxx-3Dxxxx

	// Odd bytes carry DIP reads and bit latch writes
	assign nDipRd0 = bus.nLds | nRd | nIoZone | a19 | a18 | a17;
	assign nDipRd1 = bus.nLds | nRd | nIoZone | a19 | a18 | ~a17;
	assign nBitW0 = bus.nLds | nWr | nIoZone | ~a19 | a18 | a17;
	assign nBitW1 = bus.nLds | nWr | nIoZone | ~a19 | a18 | ~a17;

	assign nRomOeL = nRd | bus.nLds | nRomZone;
	assign nRomOeU = nRd | bus.nUds | nRomZone;
	assign nWrL = nRd | bus.nLds | nWramZone;
	assign nWrU = nRd | bus.nUds | nWramZone;
	assign nWwL = nWr | bus.nLds | nWramZone;
	assign nWwU = nWr | bus.nUds | nWramZone;
	assign nPortOeL = nRd | bus.nLds | nPortZone;
	assign nPortOeU = nRd | bus.nUds | nPortZone;
	assign nPortWeL = nWr | bus.nLds | nPortZone;
	assign nPortWeU = nWr | bus.nUds | nPortZone;
	assign nPortAdrs = nPortZone | bus.nAs;	// Address latch on the slot
	assign nSromOeL = nRd | bus.nLds | nSromZone;
	assign nSromOeU = nRd | bus.nUds | nSromZone;
	assign nSramOeL = nRd | bus.nLds | nSramZone;
	assign nSramOeU = nRd | bus.nUds | nSramZone;
	assign nSramWeL = nWr | bus.nLds | nSramZone;
	assign nSramWeU = nWr | bus.nUds | nSramZone;

	// Video controller and card only answer full words
	assign nLspOe = nRd | nWordAccess | nLspcZone;
	assign nLspWe = nWr | nWordAccess | nLspcZone;
	assign nCrdO = nRd | nWordAccess | nCardZone;
	assign nCrdW = nWr | nWordAccess | nCardZone;
	assign nCrdC = nCrdO & nCrdW;	// Card select on either

	assign nPal = nPalZone | bus.nAs;

	// Strobes of different devices never overlap in one bus cycle
	assert property (@(posedge bus.nAs) $onehot0({
		~(nRomOeL & nRomOeU),
		~(nWrL & nWrU & nWwL & nWwU),
		~(nPortOeL & nPortOeU & nPortWeL & nPortWeU),
		~(nSromOeL & nSromOeU),
		~(nSramOeL & nSramOeU & nSramWeL & nSramWeU),
		~(nLspOe & nLspWe),
		~nCrdC,
		~nPal,
		~(nDipRd0 & nDipRd1 & nBitW0 & nBitW1)}))
		else $error("c1Decode: more than one device selected");

endmodule

//--- design/c1Inputs.sv
`timescale 1ns/10ps

module c1Inputs (
	input logic nCtrl1Zone,
	input logic nCtrl2Zone,
	input logic nStatusbZone,
	input logic nIcomZone,
	input c1Pkg::padT p1In,
	input c1Pkg::padT p2In,
	input logic nCd1,
	input logic nCd2,
	input logic nWp,
	input logic systemMode,
	input c1Pkg::byteT sdd,
	output c1Pkg::byteT m68kData
);
	import c1Pkg::*;

	byteT statusB;

	// Status B from the MSB down holds system mode, card write protect,
	// card detect 2 and 1, then select and start of player 2 and player 1
	assign statusB = {
		systemMode,
		nWp,
		nCd2,
		nCd1,
		p2In[9],
		p2In[8],
		p1In[9],
		p1In[8]
	};

	// Upper lane read mux over exclusive zones
	always_comb begin
		if (!nCtrl1Zone)
			m68kData = p1In[7:0];	// Player 1 stick and buttons
		else if (!nCtrl2Zone)
			m68kData = p2In[7:0];
		else if (!nStatusbZone)
			m68kData = statusB;
		else if (!nIcomZone)
			m68kData = sdd;	// Reply from the sound CPU
		else
			m68kData = 8'hFF;	// Pull-ups
	end

endmodule

//--- design/c1Pkg.sv
package c1Pkg;

	// Address lines A23 down to A17 with A23 in the top bit
	typedef logic [6:0] addrHiT;

	typedef logic [7:0] byteT;	// Upper data lane D15..D8

	// Bits 7..0 go to the control ports and bits 9..8 are start/select
	typedef logic [9:0] padT;

	typedef logic [1:0] waitCntT;	// Wait states per bus cycle

	// 68000 memory map zones of one megabyte or more
	typedef enum logic [3:0] {
		rom,	// 000000-0FFFFF program ROM
		wram,	// 100000-1FFFFF work RAM
		port,	// 200000-2FFFFF cartridge port
		io,	// 300000-3FFFFF registers, DIPs, video controller
		pal,	// 400000-7FFFFF palette
		card,	// 800000-BFFFFF memory card
		srom,	// C00000-CFFFFF system ROM
		sram,	// D00000-DFFFFF backup SRAM
		none	// E00000-FFFFFF where nothing answers
	} zoneE;

	// Slow card access
	localparam waitCntT CARD_WAIT_DEF = 2'd2;

endpackage

//--- design/c1Wait.sv
`timescale 1ns/10ps

module c1Wait #(
	parameter c1Pkg::waitCntT CARD_WAIT = c1Pkg::CARD_WAIT_DEF
) (
	input logic CLK_68KCLK,
	input logic rstN,
	c1BusIf.waiter bus,
	input logic nRomZone,
	input logic nPortZone,
	input logic nCardZone,
	input logic nRomWait,
	input logic nPWait0,
	input logic nPWait1,
	input logic pDtack,
	output logic nDtack
);
	import c1Pkg::*;

	typedef enum logic [1:0] {idle, count, ack} waitStateE;

	waitStateE state;
	waitCntT cnt;	// Edges left before acknowledge
	waitCntT zoneWait;
	logic extWait;

	// Wait states asked for by the selected zone
	always_comb begin
		if (!nRomZone)
			zoneWait = {1'b0, ~nRomWait};
		else if (!nPortZone)
			zoneWait = {~nPWait1, ~nPWait0};	// Set by the cartridge
		else if (!nCardZone)
			zoneWait = CARD_WAIT;
		else
			zoneWait = '0;
	end

	// Cartridge holds the cycle off itself
	assign extWait = ~nPortZone & pDtack;

	always_ff @(posedge CLK_68KCLK or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (!bus.nAs) begin
						if (extWait) begin
							cnt <= 2'd1;	// Release on the first edge with pDtack low
							state <= count;
						end else if (zoneWait == '0) begin
							state <= ack;
						end else begin
							cnt <= zoneWait;
							state <= count;
						end
					end
				end
				count: begin
					if (bus.nAs)
						state <= idle;	// Cycle dropped early
					else if (!extWait) begin
						if (cnt == 2'd1)
							state <= ack;
						else
							cnt <= cnt - 2'd1;
					end
				end
				ack: begin
					if (bus.nAs)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	assign nDtack = (state != ack);

	// Acknowledge only falls for a cycle the CPU was still running
	assert property (@(posedge CLK_68KCLK) disable iff (!rstN)
		$fell(nDtack) |-> !$past(bus.nAs))
		else $error("c1Wait: nDtack fell with nAs high");

endmodule

//--- design/neoC1.sv
`timescale 1ns/10ps

module neoC1 #(
	parameter c1Pkg::waitCntT CARD_WAIT = c1Pkg::CARD_WAIT_DEF
) (
	input logic CLK_68KCLK,
	input logic rstN,
	input logic [21:17] m68kAddr,
	input logic a22z, a23z,
	input logic nLds, nUds,
	input logic rw, nAs,
	input c1Pkg::byteT m68kDataIn,
	output c1Pkg::byteT m68kData,
	output logic nRomOeL, nRomOeU,
	output logic nPortOeL, nPortOeU,
	output logic nPortWeL, nPortWeU,
	output logic nPortAdrs,
	output logic nWrL, nWrU,
	output logic nWwL, nWwU,
	output logic nSromOeL, nSromOeU,
	output logic nSramOeL, nSramOeU,
	output logic nSramWeL, nSramWeU,
	output logic nLspOe, nLspWe,
	output logic nCrdO, nCrdW, nCrdC,
	output logic nBitW0, nBitW1,
	output logic nDipRd0, nDipRd1,
	output logic nPal,
	input c1Pkg::padT p1In,
	input c1Pkg::padT p2In,
	input logic nCd1, nCd2, nWp,
	input logic nRomWait, nPWait0, nPWait1, pDtack,
	input c1Pkg::byteT sdd,
	input logic systemMode,
	output logic nDtack,
	output c1Pkg::byteT soundCmd,
	output logic nSdw
);
	import c1Pkg::*;

	logic nRomZone, nPortZone, nCardZone;
	logic nCtrl1Zone, nCtrl2Zone, nStatusbZone, nIcomZone;
	zoneE zone;

	c1BusIf bus ();

	assign bus.addrHi = {a23z, a22z, m68kAddr};
	assign bus.rw = rw;
	assign bus.nAs = nAs;
	assign bus.nLds = nLds;
	assign bus.nUds = nUds;

	c1Decode decode (
		.bus(bus),
		.nRomOeL, .nRomOeU,
		.nPortOeL, .nPortOeU,
		.nPortWeL, .nPortWeU,
		.nPortAdrs,
		.nWrL, .nWrU,
		.nWwL, .nWwU,
		.nSromOeL, .nSromOeU,
		.nSramOeL, .nSramOeU,
		.nSramWeL, .nSramWeU,
		.nLspOe, .nLspWe,
		.nCrdO, .nCrdW, .nCrdC,
		.nBitW0, .nBitW1,
		.nDipRd0, .nDipRd1,
		.nPal,
		.nRomZone, .nPortZone, .nCardZone,
		.nCtrl1Zone, .nCtrl2Zone, .nStatusbZone, .nIcomZone,
		.zone
	);

	c1Wait #(
		.CARD_WAIT(CARD_WAIT)
	) waitGen (
		.CLK_68KCLK,
		.rstN,
		.bus(bus),
		.nRomZone, .nPortZone, .nCardZone,
		.nRomWait, .nPWait0, .nPWait1, .pDtack,
		.nDtack
	);

	c1Inputs inputs (
		.nCtrl1Zone, .nCtrl2Zone, .nStatusbZone, .nIcomZone,
		.p1In, .p2In,
		.nCd1, .nCd2, .nWp,
		.systemMode,
		.sdd,
		.m68kData
	);

	c1Comm comm (
		.CLK_68KCLK,
		.rstN,
		.bus(bus),
		.nIcomZone,
		.m68kDataIn,
		.soundCmd,
		.nSdw
	);

endmodule

//--- neoC1.f
design/c1Pkg.sv
design/c1BusIf.sv
design/c1Decode.sv
design/c1Wait.sv
design/c1Inputs.sv
design/c1Comm.sv
design/neoC1.sv
bench/neoC1Tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the neoC1 testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f neoC1.f \
	--top-module neoC1Tb \
	-o neoC1Sim

./obj_dir/neoC1Sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
	exit 0
else
	exit 1
fi
